/* design/bus_alert_unit.sv */
// #########################################################################
// Alert FSM giving a sticky major alert with lockdown and a minor pulse
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module bus_alert_unit
  import bus_guard_pkg::*;
(
  input  wire  clk_i,
  input  wire  rst_ni,
  input  wire  i_fault,
  input  wire  i_rsp_err,
  output logic o_alert_major,
  output logic o_alert_minor,
  output logic o_lock
);

  alert_state_e state_q;
  alert_state_e state_d;
  logic         minor_q;

  // Once a fault is seen the unit never returns to NORMAL before reset
  always_comb begin
    state_d = state_q;
    case (state_q)
      NORMAL: begin
        if (i_fault) begin
          state_d = ALERTED;
        end
      end
      ALERTED: state_d = LOCKED;
      LOCKED:  state_d = LOCKED;
      // An illegal encoding is treated as an attack and locks the bus
      default: state_d = LOCKED;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= NORMAL;
      minor_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Bus errors are reported in every state, one cycle late
      minor_q <= i_rsp_err;
    end
  end

  assign o_alert_major = (state_q != NORMAL);
  assign o_alert_minor = minor_q;
  // The arbiter stops granting for as long as the major alert stands
  assign o_lock        = o_alert_major;

endmodule

`default_nettype wire

/* design/bus_guard_config.svh */
// #########################################################################
// Width and depth macros for the shared-bus guard
// #########################################################################

`ifndef BUS_GUARD_CONFIG_SVH
`define BUS_GUARD_CONFIG_SVH

// Address width of both manager ports and the shared bus
`define BG_ADDR_W 32

// Read and write data width
`define BG_DATA_W 32

// Number of address phases that may wait for their response at once
`define BG_MAX_OUTST 4

// Width of the outstanding count, wide enough to hold BG_MAX_OUTST itself
`define BG_CNT_W 3

`endif

/* design/bus_guard_pkg.sv */
// #########################################################################
// Shared types of the bus guard: bus fields, owner index, count, alert FSM
// #########################################################################

`default_nettype none

`include "bus_guard_config.svh"

package bus_guard_pkg;

  // Byte address carried by an OBI address phase
  typedef logic [`BG_ADDR_W-1:0] addr_t;

  // Write data from a manager or read data from the subordinate
  typedef logic [`BG_DATA_W-1:0] data_t;

  // Index of the manager port, 0 is instruction fetch and 1 is data access
  typedef logic owner_t;

  // Address phases still waiting for a response
  typedef logic [`BG_CNT_W-1:0] outst_cnt_t;

  // Alert unit states, LOCKED is terminal until reset
  typedef enum logic [1:0] {
    NORMAL  = 2'b00,
    ALERTED = 2'b01,
    LOCKED  = 2'b10
  } alert_state_e;

endpackage

`default_nettype wire

/* design/bus_guard_top.sv */
// #########################################################################
// Bus guard top: arbiter, response router and alert unit between two
// OBI managers and the shared bus
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module bus_guard_top
  import bus_guard_pkg::*;
(
  input  wire        clk_i,
  input  wire        rst_ni,
  // Instruction fetch manager
  input  wire        i_m0_req,
  input  addr_t      i_m0_addr,
  input  wire        i_m0_we,
  input  data_t      i_m0_wdata,
  output logic       o_m0_gnt,
  output logic       o_m0_rvalid,
  output data_t      o_m0_rdata,
  output logic       o_m0_err,
  // Data access manager
  input  wire        i_m1_req,
  input  addr_t      i_m1_addr,
  input  wire        i_m1_we,
  input  data_t      i_m1_wdata,
  output logic       o_m1_gnt,
  output logic       o_m1_rvalid,
  output data_t      o_m1_rdata,
  output logic       o_m1_err,
  // Shared subordinate bus
  output logic       o_bus_req,
  output addr_t      o_bus_addr,
  output logic       o_bus_we,
  output data_t      o_bus_wdata,
  input  wire        i_bus_gnt,
  input  wire        i_bus_rvalid,
  input  data_t      i_bus_rdata,
  input  wire        i_bus_err,
  // Security status
  output logic       o_alert_major,
  output logic       o_alert_minor,
  output outst_cnt_t o_outst_cnt
);

  logic   push;
  owner_t push_owner;
  logic   full;
  logic   lock;
  logic   fault;
  data_t  rsp_rdata;
  logic   rsp_err;

  obi_arbiter obi_arbiter_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_m0_req     (i_m0_req),
    .i_m0_addr    (i_m0_addr),
    .i_m0_we      (i_m0_we),
    .i_m0_wdata   (i_m0_wdata),
    .i_m1_req     (i_m1_req),
    .i_m1_addr    (i_m1_addr),
    .i_m1_we      (i_m1_we),
    .i_m1_wdata   (i_m1_wdata),
    .i_bus_gnt    (i_bus_gnt),
    .i_full       (full),
    .i_lock       (lock),
    .o_m0_gnt     (o_m0_gnt),
    .o_m1_gnt     (o_m1_gnt),
    .o_bus_req    (o_bus_req),
    .o_bus_addr   (o_bus_addr),
    .o_bus_we     (o_bus_we),
    .o_bus_wdata  (o_bus_wdata),
    .o_push       (push),
    .o_push_owner (push_owner)
  );

  obi_resp_router obi_resp_router_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_push       (push),
    .i_push_owner (push_owner),
    .i_bus_rvalid (i_bus_rvalid),
    .i_bus_rdata  (i_bus_rdata),
    .i_bus_err    (i_bus_err),
    .o_m0_rvalid  (o_m0_rvalid),
    .o_m1_rvalid  (o_m1_rvalid),
    .o_rdata      (rsp_rdata),
    .o_rsp_err    (rsp_err),
    .o_full       (full),
    .o_fault      (fault),
    .o_outst_cnt  (o_outst_cnt)
  );

  bus_alert_unit bus_alert_unit_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .i_fault       (fault),
    .i_rsp_err     (rsp_err),
    .o_alert_major (o_alert_major),
    .o_alert_minor (o_alert_minor),
    .o_lock        (lock)
  );

  // Both ports share the response data, their rvalid tells which one owns it
  assign o_m0_rdata = rsp_rdata;
  assign o_m1_rdata = rsp_rdata;
  assign o_m0_err   = rsp_err;
  assign o_m1_err   = rsp_err;

endmodule

`default_nettype wire

/* design/obi_arbiter.sv */
// #########################################################################
// Round-robin arbiter placing one of two OBI managers on the shared bus
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module obi_arbiter
  import bus_guard_pkg::*;
(
  input  wire    clk_i,
  input  wire    rst_ni,
  input  wire    i_m0_req,
  input  addr_t  i_m0_addr,
  input  wire    i_m0_we,
  input  data_t  i_m0_wdata,
  input  wire    i_m1_req,
  input  addr_t  i_m1_addr,
  input  wire    i_m1_we,
  input  data_t  i_m1_wdata,
  input  wire    i_bus_gnt,
  input  wire    i_full,
  input  wire    i_lock,
  output logic   o_m0_gnt,
  output logic   o_m1_gnt,
  output logic   o_bus_req,
  output addr_t  o_bus_addr,
  output logic   o_bus_we,
  output data_t  o_bus_wdata,
  output logic   o_push,
  output owner_t o_push_owner
);

  // Port that wins a tie, 0 after reset
  owner_t rr_q;
  // Port whose fields are currently driven onto the bus
  owner_t sel;
  // No new address phase may start while the record is full or in lockdown
  logic   allow;

  assign allow = ~i_full & ~i_lock;

  // A lone requester always wins, the pointer only breaks ties
  always_comb begin
    if (i_m0_req && i_m1_req) begin
      sel = rr_q;
    end else if (i_m1_req) begin
      sel = 1'b1;
    end else begin
      sel = 1'b0;
    end
  end

  // The bus sees a request only when the guard lets one through
  assign o_bus_req   = (i_m0_req | i_m1_req) & allow;
  assign o_bus_addr  = sel ? i_m1_addr : i_m0_addr;
  assign o_bus_we    = sel ? i_m1_we : i_m0_we;
  assign o_bus_wdata = sel ? i_m1_wdata : i_m0_wdata;

  // Grant is forwarded in the same cycle, to the selected port only
  assign o_m0_gnt = o_bus_req & i_bus_gnt & (sel == 1'b0);
  assign o_m1_gnt = o_bus_req & i_bus_gnt & (sel == 1'b1);

  // A completed address phase is handed to the router with its owner
  assign o_push       = o_bus_req & i_bus_gnt;
  assign o_push_owner = sel;

  // After each completed phase the other port gets priority
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rr_q <= 1'b0;
    end else if (o_push) begin
      rr_q <= ~sel;
    end
  end

endmodule

`default_nettype wire

/* design/obi_resp_router.sv */
// #########################################################################
// In-order owner record that steers OBI responses back to their manager
// and flags a response that has no outstanding address phase
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "bus_guard_config.svh"

module obi_resp_router
  import bus_guard_pkg::*;
(
  input  wire        clk_i,
  input  wire        rst_ni,
  input  wire        i_push,
  input  owner_t     i_push_owner,
  input  wire        i_bus_rvalid,
  input  data_t      i_bus_rdata,
  input  wire        i_bus_err,
  output logic       o_m0_rvalid,
  output logic       o_m1_rvalid,
  output data_t      o_rdata,
  output logic       o_rsp_err,
  output logic       o_full,
  output logic       o_fault,
  output outst_cnt_t o_outst_cnt
);

  localparam int unsigned ptr_w = (`BG_MAX_OUTST > 1) ? $clog2(`BG_MAX_OUTST) : 1;

  typedef logic [ptr_w-1:0] ptr_t;

  // Circular FIFO of owners, the oldest sits at the read pointer
  owner_t     owner_q [`BG_MAX_OUTST];
  ptr_t       wr_ptr_q;
  ptr_t       rd_ptr_q;
  outst_cnt_t cnt_q;
  logic       empty;
  logic       push_ok;
  logic       pop;
  owner_t     head_owner;

  // Advance a pointer and wrap at the record depth, any depth works
  function automatic ptr_t ptr_inc(input ptr_t p);
    ptr_t nxt;
    if (p == ptr_t'(`BG_MAX_OUTST - 1)) begin
      nxt = '0;
    end else begin
      nxt = p + ptr_t'(1);
    end
    return nxt;
  endfunction

  assign empty  = (cnt_q == '0);
  assign o_full = (cnt_q == outst_cnt_t'(`BG_MAX_OUTST));

  // The arbiter already holds off when full, this keeps the record intact anyway
  assign push_ok = i_push & ~o_full;

  // Only a response with a matching address phase is consumed
  assign pop     = i_bus_rvalid & ~empty;
  // A response into an empty record is the protocol fault, it is never routed
  assign o_fault = i_bus_rvalid & empty;

  assign head_owner = owner_q[rd_ptr_q];

  assign o_m0_rvalid = pop & (head_owner == 1'b0);
  assign o_m1_rvalid = pop & (head_owner == 1'b1);

  // Data and error are masked outside a routed response so a glitch leaks nothing
  assign o_rdata   = pop ? i_bus_rdata : '0;
  assign o_rsp_err = pop & i_bus_err;

  assign o_outst_cnt = cnt_q;

  // Owner storage needs no reset, entries are only read once counted
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      owner_q[wr_ptr_q] <= i_push_owner;
    end
  end

  // Pointers and count, a push and a pop together leave the count alone
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_ok, pop})
        2'b10:   cnt_q <= cnt_q + outst_cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - outst_cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the bus guard testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f sources.f \
  --top-module tb_bus_guard \
  -o sim_bus_guard

out="$(./obj_dir/sim_bus_guard)"
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
  exit 0
else
  exit 1
fi

/* sources.f */
+incdir+design
design/bus_guard_pkg.sv
design/obi_arbiter.sv
design/obi_resp_router.sv
design/bus_alert_unit.sv
design/bus_guard_top.sv
verification/tb_obi_subordinate.sv
verification/tb_bus_guard.sv

/* verification/tb_bus_guard.sv */
// ##########################################################################
// Testbench top for the bus guard with clock, reset, manager drivers,
// checks, directed tests and summary
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "bus_guard_config.svh"

module tb_bus_guard
  import bus_guard_pkg::*;
;

  logic clk_i;
  logic rst_ni;
  logic m0_req, m0_we, m1_req, m1_we;
  addr_t m0_addr, m1_addr, bus_addr;
  data_t m0_wdata, m1_wdata;
  wire m0_gnt, m0_rvalid, m0_err, m1_gnt, m1_rvalid, m1_err;
  data_t m0_rdata, m1_rdata, bus_wdata, bus_rdata;
  wire bus_req, bus_we, bus_gnt, bus_rvalid, bus_err;
  wire alert_major, alert_minor;
  outst_cnt_t outst_cnt;
  logic random_stall, hold_rsp;

  // Commands are {we, addr, wdata} and expected responses are {err, rdata}
  logic [64:0] cmd_q0 [$];
  logic [64:0] cmd_q1 [$];
  logic [32:0] exp_q0 [$];
  logic [32:0] exp_q1 [$];
  data_t       mirror [256];
  logic [64:0] cmd;
  logic [32:0] rsp;
  logic        rr_next;
  logic        minor_exp;
  data_t       last_rdata0;
  int          rsp_cnt0, rsp_cnt1, max_cnt, minor_pulses;
  int          errors, tests, cycles;
  string       cur_test;

  bus_guard_top bus_guard_top_inst (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .i_m0_req(m0_req), .i_m0_addr(m0_addr), .i_m0_we(m0_we), .i_m0_wdata(m0_wdata),
    .o_m0_gnt(m0_gnt), .o_m0_rvalid(m0_rvalid), .o_m0_rdata(m0_rdata), .o_m0_err(m0_err),
    .i_m1_req(m1_req), .i_m1_addr(m1_addr), .i_m1_we(m1_we), .i_m1_wdata(m1_wdata),
    .o_m1_gnt(m1_gnt), .o_m1_rvalid(m1_rvalid), .o_m1_rdata(m1_rdata), .o_m1_err(m1_err),
    .o_bus_req(bus_req), .o_bus_addr(bus_addr), .o_bus_we(bus_we),
    .o_bus_wdata(bus_wdata), .i_bus_gnt(bus_gnt), .i_bus_rvalid(bus_rvalid),
    .i_bus_rdata(bus_rdata), .i_bus_err(bus_err),
    .o_alert_major(alert_major), .o_alert_minor(alert_minor), .o_outst_cnt(outst_cnt)
  );

  tb_obi_subordinate tb_obi_subordinate_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .i_req(bus_req), .i_addr(bus_addr),
    .i_we(bus_we), .i_wdata(bus_wdata), .i_random_stall(random_stall),
    .i_hold_rsp(hold_rsp), .o_gnt(bus_gnt), .o_rvalid(bus_rvalid),
    .o_rdata(bus_rdata), .o_err(bus_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Limit well above the length of all tests together
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= 2000) begin
      $display("Timeout: the run did not finish within %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors = errors + 1;
      $display("[ERROR] %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    end
  endtask

  task automatic report(input string msg);
    errors = errors + 1;
    $display("%s: %s", cur_test, msg);
  endtask

  // Expected response of a granted command as worked out from the mirror memory
  task automatic record_grant(input int port, input logic [64:0] c);
    logic [7:0] idx;
    // Word index of the byte address, the same one the memory model uses
    idx = c[41:34];
    if (c[63:32] >= 32'hdead_0000) begin
      rsp = {1'b1, 32'h0};
    end else if (c[64]) begin
      mirror[idx] = c[31:0];
      rsp = {1'b0, 32'h0};
    end else begin
      rsp = {1'b0, mirror[idx]};
    end
    if (port == 0) begin
      exp_q0.push_back(rsp);
    end else begin
      exp_q1.push_back(rsp);
    end
  endtask

  // Manager drivers change inputs on the falling edge and sample 1 ns later
  always @(negedge clk_i) begin
    m0_req = (cmd_q0.size() > 0);
    m1_req = (cmd_q1.size() > 0);
    if (m0_req) {m0_we, m0_addr, m0_wdata} = cmd_q0[0];
    if (m1_req) {m1_we, m1_addr, m1_wdata} = cmd_q1[0];
    #1;
    if (m0_gnt && m1_gnt) report("both ports granted in one cycle");
    // With both ports asking, the port not granted last must win
    if (m0_req && m1_req && (m0_gnt || m1_gnt)) begin
      check("grant order", 32'(rr_next), 32'(m1_gnt));
    end
    if (m0_gnt) begin
      cmd = cmd_q0.pop_front();
      record_grant(0, cmd);
      rr_next = 1'b1;
    end
    if (m1_gnt) begin
      cmd = cmd_q1.pop_front();
      record_grant(1, cmd);
      rr_next = 1'b0;
    end
    check("alert_minor", 32'(minor_exp), 32'(alert_minor));
    minor_exp = 1'b0;
    if (alert_minor) minor_pulses = minor_pulses + 1;
    if (m0_rvalid) begin
      if (exp_q0.size() == 0) begin
        report("port 0 got a response it never asked for");
      end else begin
        rsp = exp_q0.pop_front();
        check("port 0 rdata", rsp[31:0], m0_rdata);
        check("port 0 err", 32'(rsp[32]), 32'(m0_err));
        minor_exp = rsp[32];
      end
      last_rdata0 = m0_rdata;
      rsp_cnt0 = rsp_cnt0 + 1;
    end
    if (m1_rvalid) begin
      if (exp_q1.size() == 0) begin
        report("port 1 got a response it never asked for");
      end else begin
        rsp = exp_q1.pop_front();
        check("port 1 rdata", rsp[31:0], m1_rdata);
        check("port 1 err", 32'(rsp[32]), 32'(m1_err));
        minor_exp = rsp[32];
      end
      rsp_cnt1 = rsp_cnt1 + 1;
    end
    if (int'(outst_cnt) > max_cnt) max_cnt = int'(outst_cnt);
  end

  // Moves to 2 ns after a falling edge so the drivers have already sampled
  task automatic step(input int n);
    repeat (n) @(negedge clk_i);
    #2;
  endtask

  task automatic wait_idle();
    while (cmd_q0.size() + cmd_q1.size() + exp_q0.size() + exp_q1.size() > 0) begin
      step(1);
    end
    step(2);
  endtask

  task automatic finish_test();
    tests = tests + 1;
    $display("%s: done, errors so far %0d", cur_test, errors);
  endtask

  task automatic test_reset_state();
    cur_test = "reset_state";
    check("bus_req", 0, 32'(bus_req));
    check("gnt", 0, 32'({m0_gnt, m1_gnt}));
    check("rvalid", 0, 32'({m0_rvalid, m1_rvalid}));
    check("alerts", 0, 32'({alert_major, alert_minor}));
    check("outst_cnt", 0, 32'(outst_cnt));
    finish_test();
  endtask

  task automatic test_write_read();
    cur_test = "write_read";
    rsp_cnt0 = 0;
    rsp_cnt1 = 0;
    cmd_q0.push_back({1'b1, 32'h0000_0040, 32'h1234_5678});
    cmd_q0.push_back({1'b0, 32'h0000_0040, 32'h0});
    wait_idle();
    check("port 0 responses", 2, rsp_cnt0);
    check("port 1 responses", 0, rsp_cnt1);
    check("read back", 32'h1234_5678, last_rdata0);
    finish_test();
  endtask

  task automatic test_concurrent();
    cur_test = "concurrent";
    rsp_cnt0 = 0;
    rsp_cnt1 = 0;
    random_stall = 1'b1;
    cmd_q0.push_back({1'b0, 32'h0000_0100, 32'h0});
    cmd_q0.push_back({1'b1, 32'h0000_0104, 32'haaaa_0001});
    cmd_q0.push_back({1'b0, 32'h0000_0104, 32'h0});
    cmd_q0.push_back({1'b0, 32'h0000_0108, 32'h0});
    cmd_q1.push_back({1'b1, 32'h0000_0200, 32'hbbbb_0002});
    cmd_q1.push_back({1'b0, 32'h0000_0204, 32'h0});
    cmd_q1.push_back({1'b0, 32'h0000_0200, 32'h0});
    cmd_q1.push_back({1'b1, 32'h0000_0208, 32'hcccc_0003});
    wait_idle();
    random_stall = 1'b0;
    check("port 0 responses", 4, rsp_cnt0);
    check("port 1 responses", 4, rsp_cnt1);
    finish_test();
  endtask

  task automatic test_backpressure();
    cur_test = "backpressure";
    rsp_cnt1 = 0;
    max_cnt  = 0;
    hold_rsp = 1'b1;
    for (int i = 0; i < `BG_MAX_OUTST + 2; i++) begin
      cmd_q1.push_back({i < 3, 32'h0000_0300 + 32'(4 * (i % 3)), 32'hd000_0000 + 32'(i)});
    end
    step(8);
    check("outst_cnt while held", `BG_MAX_OUTST, 32'(outst_cnt));
    check("requests waiting", 2, cmd_q1.size());
    hold_rsp = 1'b0;
    wait_idle();
    check("peak outst_cnt", `BG_MAX_OUTST, max_cnt);
    check("port 1 responses", `BG_MAX_OUTST + 2, rsp_cnt1);
    finish_test();
  endtask

  task automatic test_bus_error();
    cur_test = "bus_error";
    minor_pulses = 0;
    cmd_q0.push_back({1'b0, 32'hdead_0000, 32'h0});
    wait_idle();
    check("minor pulse cycles", 1, minor_pulses);
    check("alert_major", 0, 32'(alert_major));
    finish_test();
  endtask

  task automatic test_spurious();
    cur_test = "spurious";
    tb_obi_subordinate_inst.inject_spurious();
    step(1);
    check("manager rvalid", 0, 32'({m0_rvalid, m1_rvalid}));
    check("alert_major same cycle", 0, 32'(alert_major));
    // A request after the fault must stay blocked for good
    cmd_q1.push_back({1'b0, 32'h0000_0010, 32'h0});
    for (int i = 0; i < 20; i++) begin
      step(1);
      check("alert_major", 1, 32'(alert_major));
      check("m1_gnt", 0, 32'(m1_gnt));
      check("bus_req", 0, 32'(bus_req));
      // The unmatched response must not wrap the outstanding count
      check("outst_cnt", 0, 32'(outst_cnt));
    end
    finish_test();
  endtask

  initial begin
    void'($urandom(14));
    for (int i = 0; i < 256; i++) begin
      mirror[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i * 3)};
    end
    {m0_req, m0_we, m1_req, m1_we} = '0;
    {m0_addr, m0_wdata, m1_addr, m1_wdata} = '0;
    {random_stall, hold_rsp, rr_next, minor_exp} = '0;
    {rsp_cnt0, rsp_cnt1, max_cnt, minor_pulses} = '0;
    {errors, tests, cycles} = '0;
    last_rdata0 = '0;
    cur_test = "reset";
    rst_ni = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    step(1);
    test_reset_state();
    test_write_read();
    test_concurrent();
    test_backpressure();
    test_bus_error();
    test_spurious();
    $display("Tests run: %0d, errors: %0d, cycles: %0d", tests, errors, cycles);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/tb_obi_subordinate.sv */
// ##########################################################################
// OBI memory model for the shared bus: random stalls, in-order responses
// and injection of a spurious response
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module tb_obi_subordinate
  import bus_guard_pkg::*;
(
  input  wire   clk_i,
  input  wire   rst_ni,
  input  wire   i_req,
  input  addr_t i_addr,
  input  wire   i_we,
  input  data_t i_wdata,
  input  wire   i_random_stall,
  input  wire   i_hold_rsp,
  output logic  o_gnt,
  output logic  o_rvalid,
  output data_t o_rdata,
  output logic  o_err
);

  data_t       mem [256];
  int unsigned cyc;
  int unsigned last_due;
  int unsigned due_q [$];
  data_t       data_q [$];
  logic        err_q [$];
  logic        spur_pending;
  int unsigned due;
  logic [7:0]  idx;

  // Every word gets a value built from its full word index
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i * 3)};
    end
    o_gnt        = 1'b0;
    o_rvalid     = 1'b0;
    o_rdata      = '0;
    o_err        = 1'b0;
    cyc          = 0;
    last_due     = 0;
    spur_pending = 1'b0;
  end

  // Makes the model drive one rvalid with no address phase behind it
  task automatic inject_spurious();
    spur_pending = 1'b1;
  endtask

  always @(negedge clk_i) begin
    cyc = cyc + 1;
    o_rvalid = 1'b0;
    o_rdata  = '0;
    o_err    = 1'b0;
    if (!rst_ni) begin
      o_gnt = 1'b0;
      due_q.delete();
      data_q.delete();
      err_q.delete();
    end else begin
      // A stall bit set one time in four keeps the grant low
      o_gnt = i_random_stall ? ($urandom_range(3) != 0) : 1'b1;
      if (spur_pending) begin
        o_rvalid     = 1'b1;
        spur_pending = 1'b0;
      end else if (!i_hold_rsp && due_q.size() > 0 && due_q[0] <= cyc) begin
        o_rvalid = 1'b1;
        o_rdata  = data_q.pop_front();
        o_err    = err_q.pop_front();
        void'(due_q.pop_front());
      end
      // Bus signals are settled here and match what the next rising edge sees
      #1;
      if (i_req && o_gnt) begin
        idx = i_addr[9:2];
        due = cyc + $urandom_range(1, 3);
        // Responses stay in order even when a later one draws a shorter delay
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        due_q.push_back(due);
        if (i_addr >= 32'hdead_0000) begin
          data_q.push_back('0);
          err_q.push_back(1'b1);
        end else if (i_we) begin
          mem[idx] = i_wdata;
          data_q.push_back('0);
          err_q.push_back(1'b0);
        end else begin
          data_q.push_back(mem[idx]);
          err_q.push_back(1'b0);
        end
      end
    end
  end

endmodule

`default_nettype wire
